// File: src.f
+incdir+test
source/rv_decode_pkg.sv
source/imm_gen.sv
source/ctrl_decode.sv
source/decode_stage.sv
test/decode_asserts.sv
test/decode_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module decode_tb -f src.f -o decode_sim \
    && ./obj_dir/decode_sim > sim.log 2>&1
grep -q "^all tests passed$" sim.log && echo "simulation ok" && exit 0 \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: test/decode_vectors.svh
// columns: word, rs1, rs2, rd, {reg_wen,branch,jump,jalr}, alu_op, alu_src,
// {mem_re,mem_we}, mem_size, mem_unsigned, wmask, word_op, {illegal,ebreak}, imm
task automatic load_vectors();
    add_vec(32'h002081B3, 1, 2, 3, 4'b1000,  0, 0, 2'b00, 0, 0, 8'h00, 0, 2'b00, 64'h0); // add
    add_vec(32'h402081B3, 1, 2, 3, 4'b1000,  1, 0, 2'b00, 0, 0, 8'h00, 0, 2'b00, 64'h0); // sub
    add_vec(32'h022081B3, 1, 2, 3, 4'b1000, 10, 0, 2'b00, 0, 0, 8'h00, 0, 2'b00, 64'h0); // mul
    add_vec(32'h0020F1B3, 1, 2, 3, 4'b1000,  2, 0, 2'b00, 0, 0, 8'h00, 0, 2'b00, 64'h0); // and
    add_vec(32'h0020E1B3, 1, 2, 3, 4'b1000,  3, 0, 2'b00, 0, 0, 8'h00, 0, 2'b00, 64'h0); // or
    add_vec(32'h0020B1B3, 1, 2, 3, 4'b1000,  6, 0, 2'b00, 0, 0, 8'h00, 0, 2'b00, 64'h0); // sltu
    add_vec(32'h0020A1B3, 1, 2, 3, 4'b1000,  5, 0, 2'b00, 0, 0, 8'h00, 0, 2'b00, 64'h0); // slt
    add_vec(32'h0220D1B3, 1, 2, 3, 4'b1000, 11, 0, 2'b00, 0, 0, 8'h00, 0, 2'b00, 64'h0); // divu
    add_vec(32'h0220F1B3, 1, 2, 3, 4'b1000, 12, 0, 2'b00, 0, 0, 8'h00, 0, 2'b00, 64'h0); // remu
    add_vec(32'h002081BB, 1, 2, 3, 4'b1000,  0, 0, 2'b00, 0, 0, 8'h00, 1, 2'b00, 64'h0); // addw
    add_vec(32'h402081BB, 1, 2, 3, 4'b1000,  1, 0, 2'b00, 0, 0, 8'h00, 1, 2'b00, 64'h0); // subw
    add_vec(32'h022081BB, 1, 2, 3, 4'b1000, 10, 0, 2'b00, 0, 0, 8'h00, 1, 2'b00, 64'h0); // mulw
    add_vec(32'h002091BB, 1, 2, 3, 4'b1000,  7, 0, 2'b00, 0, 0, 8'h00, 1, 2'b00, 64'h0); // sllw
    add_vec(32'h0220C1BB, 1, 2, 3, 4'b1000, 13, 0, 2'b00, 0, 0, 8'h00, 1, 2'b00, 64'h0); // divw
    add_vec(32'h0220E1BB, 1, 2, 3, 4'b1000, 14, 0, 2'b00, 0, 0, 8'h00, 1, 2'b00, 64'h0); // remw
    add_vec(32'hFFF08193, 1, 0, 3, 4'b1000,  0, 1, 2'b00, 0, 0, 8'h00, 0, 2'b00, -64'sd1); // addi
    add_vec(32'h0050B193, 1, 0, 3, 4'b1000,  6, 1, 2'b00, 0, 0, 8'h00, 0, 2'b00, 64'h5); // sltiu
    add_vec(32'h8000C193, 1, 0, 3, 4'b1000,  4, 1, 2'b00, 0, 0, 8'h00, 0, 2'b00, -64'sd2048);
    add_vec(32'h7FF0E193, 1, 0, 3, 4'b1000,  3, 1, 2'b00, 0, 0, 8'h00, 0, 2'b00, 64'h7FF); // ori
    add_vec(32'h0F00F193, 1, 0, 3, 4'b1000,  2, 1, 2'b00, 0, 0, 8'h00, 0, 2'b00, 64'hF0); // andi
    add_vec(32'h03F09193, 1, 0, 3, 4'b1000,  7, 1, 2'b00, 0, 0, 8'h00, 0, 2'b00, 64'd63); // slli
    add_vec(32'h4210D193, 1, 0, 3, 4'b1000,  9, 1, 2'b00, 0, 0, 8'h00, 0, 2'b00, 64'd33); // srai
    add_vec(32'hFF00819B, 1, 0, 3, 4'b1000,  0, 1, 2'b00, 0, 0, 8'h00, 1, 2'b00, -64'sd16);
    add_vec(32'h01F0919B, 1, 0, 3, 4'b1000,  7, 1, 2'b00, 0, 0, 8'h00, 1, 2'b00, 64'd31);
    add_vec(32'h0070D19B, 1, 0, 3, 4'b1000,  8, 1, 2'b00, 0, 0, 8'h00, 1, 2'b00, 64'd7); // srliw
    add_vec(32'h41F0D19B, 1, 0, 3, 4'b1000,  9, 1, 2'b00, 0, 0, 8'h00, 1, 2'b00, 64'd31);
    add_vec(32'h0080A183, 1, 0, 3, 4'b1000,  0, 1, 2'b10, 2, 0, 8'h00, 0, 2'b00, 64'd8); // lw
    add_vec(32'hFF80B183, 1, 0, 3, 4'b1000,  0, 1, 2'b10, 3, 0, 8'h00, 0, 2'b00, -64'sd8); // ld
    add_vec(32'h0000C183, 1, 0, 3, 4'b1000,  0, 1, 2'b10, 0, 1, 8'h00, 0, 2'b00, 64'd0); // lbu
    add_vec(32'h00209183, 1, 0, 3, 4'b1000,  0, 1, 2'b10, 1, 0, 8'h00, 0, 2'b00, 64'd2); // lh
    add_vec(32'h0100D183, 1, 0, 3, 4'b1000,  0, 1, 2'b10, 1, 1, 8'h00, 0, 2'b00, 64'h10); // lhu
    add_vec(32'h00208223, 1, 2, 0, 4'b0000,  0, 1, 2'b01, 0, 0, 8'h01, 0, 2'b00, 64'd4); // sb
    add_vec(32'hFE209E23, 1, 2, 0, 4'b0000,  0, 1, 2'b01, 1, 0, 8'h03, 0, 2'b00, -64'sd4); // sh
    add_vec(32'h0220A023, 1, 2, 0, 4'b0000,  0, 1, 2'b01, 2, 0, 8'h0F, 0, 2'b00, 64'h20); // sw
    add_vec(32'h0020B423, 1, 2, 0, 4'b0000,  0, 1, 2'b01, 3, 0, 8'hFF, 0, 2'b00, 64'd8); // sd
    add_vec(32'h00208863, 1, 2, 0, 4'b0100, 15, 0, 2'b00, 0, 0, 8'h00, 0, 2'b00, 64'h10); // beq
    add_vec(32'hFE209EE3, 1, 2, 0, 4'b0100, 16, 0, 2'b00, 0, 0, 8'h00, 0, 2'b00, -64'sd4); // bne
    add_vec(32'h0020C463, 1, 2, 0, 4'b0100, 17, 0, 2'b00, 0, 0, 8'h00, 0, 2'b00, 64'd8); // blt
    add_vec(32'h0020D0E3, 1, 2, 0, 4'b0100, 18, 0, 2'b00, 0, 0, 8'h00, 0, 2'b00, 64'h800); // bge
    add_vec(32'h0220E063, 1, 2, 0, 4'b0100, 19, 0, 2'b00, 0, 0, 8'h00, 0, 2'b00, 64'h20); // bltu
    add_vec(32'h0020F663, 1, 2, 0, 4'b0100, 20, 0, 2'b00, 0, 0, 8'h00, 0, 2'b00, 64'hC); // bgeu
    add_vec(32'h008000EF, 0, 0, 1, 4'b1010,  0, 3, 2'b00, 0, 0, 8'h00, 0, 2'b00, 64'd8); // jal
    add_vec(32'hFF8100E7, 2, 0, 1, 4'b1011,  0, 3, 2'b00, 0, 0, 8'h00, 0, 2'b00, -64'sd8); // jalr
    add_vec(32'h800002B7, 0, 0, 5, 4'b1000,  0, 1, 2'b00, 0, 0, 8'h00, 0, 2'b00,
            64'hFFFF_FFFF_8000_0000); // lui
    add_vec(32'h12345297, 0, 0, 5, 4'b1000,  0, 2, 2'b00, 0, 0, 8'h00, 0, 2'b00, 64'h12345000);
    add_vec(32'hFFFFFFFF, 0, 0, 0, 4'b0000,  0, 0, 2'b00, 0, 0, 8'h00, 0, 2'b10, 64'd0); // opcode
    add_vec(32'h202081B3, 0, 0, 0, 4'b0000,  0, 0, 2'b00, 0, 0, 8'h00, 0, 2'b10, 64'd0); // funct7
    add_vec(32'h0020C023, 0, 0, 0, 4'b0000,  0, 0, 2'b00, 0, 0, 8'h00, 0, 2'b10, 64'd0); // store f3
    add_vec(32'h00100073, 0, 0, 0, 4'b0000,  0, 0, 2'b00, 0, 0, 8'h00, 0, 2'b01, 64'd0); // ebreak
endtask

// File: test/decode_tb.sv
`timescale 1ns/1ps

module decode_tb;

    logic                   clk = 1'b0;
    logic                   arst_n;
    logic                   inst_valid;
    rv_decode_pkg::inst_t   inst;
    logic                   out_valid;
    rv_decode_pkg::decode_t dec;

    logic [31:0]            words[$];
    rv_decode_pkg::decode_t exps[$];
    logic [31:0]            seed = 32'h2ffa0048;
    int                     limit = 1000;
    int                     cycles = 0;
    int                     pass_cnt = 0;
    int                     fail_cnt = 0;
    int                     errors = 0;
    bit                     prev_v = 1'b0;
    int                     prev_idx = 0;
    rv_decode_pkg::decode_t held = '0;

    decode_stage UUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .out_valid  (out_valid),
        .dec        (dec)
    );

    bind decode_stage decode_asserts u_asserts (
        .clk(clk), .arst_n(arst_n), .inst_valid(inst_valid), .out_valid(out_valid), .dec(dec)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic add_vec(input logic [31:0] w, input int rs1, input int rs2, input int rd,
                           input logic [3:0] fl, input int op, input int src,
                           input logic [1:0] mem, input int size, input int uns,
                           input logic [7:0] wm, input logic wop, input logic [1:0] ie,
                           input logic [63:0] imm);
        rv_decode_pkg::decode_t d;
        d = {rs1[4:0], rs2[4:0], rd[4:0], fl, op[4:0], src[1:0], mem, size[1:0], uns[0],
             wm, wop, ie, imm}; // ctrl_t field order followed by imm
        words.push_back(w);
        exps.push_back(d);
    endtask

    `include "decode_vectors.svh"

    // checks the bundle launched on the previous falling edge
    task automatic check_prev();
        bit ok;
        ok = 1'b1;
        if (prev_v) begin
            if (out_valid !== 1'b1) begin
                $display("Mismatch at %0t ns: test %0d out_valid low", $time, prev_idx);
                ok = 1'b0;
            end
            if (dec.ctrl !== exps[prev_idx].ctrl) begin
                $display("Mismatch at %0t ns: test %0d ctrl got %h expected %h", $time,
                         prev_idx, dec.ctrl, exps[prev_idx].ctrl);
                ok = 1'b0;
            end
            if (dec.imm !== exps[prev_idx].imm) begin
                $display("Mismatch at %0t ns: test %0d imm got %h expected %h", $time,
                         prev_idx, dec.imm, exps[prev_idx].imm);
                ok = 1'b0;
            end
            if (ok) pass_cnt++;
            else fail_cnt++;
            held = exps[prev_idx];
            $display("test %0d word %h %s", prev_idx, words[prev_idx], ok ? "ok" : "wrong");
        end else begin
            if (out_valid !== 1'b0) begin
                $display("Mismatch at %0t ns: out_valid high after idle cycle", $time);
                errors++;
            end
            if (dec !== held) begin
                $display("Mismatch at %0t ns: dec changed on idle cycle", $time);
                errors++;
            end
        end
    endtask

    task automatic step(input bit v, input int idx);
        @(negedge clk);
        check_prev();
        inst_valid = v;
        if (v) inst = words[idx];
        else inst = lcg_next(); // junk word while idle
        prev_v   = v;
        prev_idx = idx;
    endtask

    initial begin
        int gap;
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        load_vectors();
        limit = words.size() * 5 + 20;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        if (out_valid !== 1'b0 || dec !== '0) begin
            $display("Mismatch at %0t ns: outputs not cleared by reset", $time);
            errors++;
        end
        for (int i = 0; i < words.size(); i++) begin
            gap = lcg_next() >> 16;
            gap = gap % 4; // 0 to 3 idle cycles
            repeat (gap) step(1'b0, 0);
            step(1'b1, i);
        end
        step(1'b0, 0);
        step(1'b0, 0);
        $display("%0d tests ok, %0d tests wrong, %0d other errors", pass_cnt, fail_cnt, errors);
        if (fail_cnt == 0 && errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: test/decode_asserts.sv
`timescale 1ns/1ps

module decode_asserts (
    input logic                   clk,
    input logic                   arst_n,
    input logic                   inst_valid,
    input logic                   out_valid,
    input rv_decode_pkg::decode_t dec
);

    // one-cycle strobe latency
    a_valid_lat: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == $past(inst_valid))
        else $error("out_valid does not follow inst_valid by one cycle");

    a_illegal_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        dec.ctrl.illegal |-> !(dec.ctrl.reg_wen || dec.ctrl.mem_we ||
                               dec.ctrl.branch || dec.ctrl.jump))
        else $error("illegal bundle has side effects");

    a_store_no_wb: assert property (@(posedge clk) disable iff (!arst_n)
        !(dec.ctrl.mem_we && dec.ctrl.reg_wen))
        else $error("store also writes a register");

    a_reset_zero: assert property (@(posedge clk)
        !arst_n |-> (out_valid == 1'b0 && dec == '0))
        else $error("outputs not zero in reset");

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    inst_valid,
    input  rv_decode_pkg::inst_t    inst,
    output logic                    out_valid,
    output rv_decode_pkg::decode_t  dec
);

    rv_decode_pkg::ctrl_t               ctrl_next;
    rv_decode_pkg::imm_sel_e            imm_sel;
    logic [rv_decode_pkg::XLEN-1:0]     imm_next;

    ctrl_decode u_ctrl (
        .inst    (inst),
        .ctrl    (ctrl_next),
        .imm_sel (imm_sel)
    );

    imm_gen u_imm (
        .inst    (inst),
        .imm_sel (imm_sel),
        .imm     (imm_next)
    );

    // strobe follows inst_valid by one cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= inst_valid;
        end
    end

    // bundle holds its last value on idle cycles
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec <= '0;
        end else if (inst_valid) begin
            dec.ctrl <= ctrl_next;
            dec.imm  <= imm_next;
        end
    end

endmodule

// File: source/ctrl_decode.sv
`timescale 1ns/1ps

module ctrl_decode (
    input  rv_decode_pkg::inst_t     inst,
    output rv_decode_pkg::ctrl_t     ctrl,
    output rv_decode_pkg::imm_sel_e  imm_sel
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       bad;

    assign opcode = inst.r_fmt.opcode;
    assign funct3 = inst.r_fmt.funct3;
    assign funct7 = inst.r_fmt.funct7;

    always_comb begin
        ctrl    = '0;
        imm_sel = rv_decode_pkg::IMM_NONE;
        bad     = 1'b0;
        case (opcode)
            rv_decode_pkg::OPC_OP, rv_decode_pkg::OPC_OP_32: begin
                ctrl.reg_wen = 1'b1;
                ctrl.rs1     = inst.r_fmt.rs1;
                ctrl.rs2     = inst.r_fmt.rs2;
                ctrl.rd      = inst.r_fmt.rd;
                ctrl.alu_src = rv_decode_pkg::SRC_REG;
                ctrl.word_op = (opcode == rv_decode_pkg::OPC_OP_32);
                case ({ctrl.word_op, funct3, funct7})
                    {1'b0, 3'b000, rv_decode_pkg::F7_BASE},
                    {1'b1, 3'b000, rv_decode_pkg::F7_BASE}:   ctrl.alu_op = rv_decode_pkg::ALU_ADD;
                    {1'b0, 3'b000, rv_decode_pkg::F7_ALT},
                    {1'b1, 3'b000, rv_decode_pkg::F7_ALT}:    ctrl.alu_op = rv_decode_pkg::ALU_SUB;
                    {1'b0, 3'b000, rv_decode_pkg::F7_MULDIV},
                    {1'b1, 3'b000, rv_decode_pkg::F7_MULDIV}: ctrl.alu_op = rv_decode_pkg::ALU_MUL;
                    {1'b0, 3'b111, rv_decode_pkg::F7_BASE}:   ctrl.alu_op = rv_decode_pkg::ALU_AND;
                    {1'b0, 3'b111, rv_decode_pkg::F7_MULDIV}: ctrl.alu_op = rv_decode_pkg::ALU_REMU;
                    {1'b0, 3'b110, rv_decode_pkg::F7_BASE}:   ctrl.alu_op = rv_decode_pkg::ALU_OR;
                    {1'b0, 3'b011, rv_decode_pkg::F7_BASE}:   ctrl.alu_op = rv_decode_pkg::ALU_SLTU;
                    {1'b0, 3'b010, rv_decode_pkg::F7_BASE}:   ctrl.alu_op = rv_decode_pkg::ALU_SLT;
                    {1'b0, 3'b101, rv_decode_pkg::F7_MULDIV}: ctrl.alu_op = rv_decode_pkg::ALU_DIVU;
                    {1'b1, 3'b001, rv_decode_pkg::F7_BASE}:   ctrl.alu_op = rv_decode_pkg::ALU_SLL;
                    {1'b1, 3'b100, rv_decode_pkg::F7_MULDIV}: ctrl.alu_op = rv_decode_pkg::ALU_DIVW;
                    {1'b1, 3'b110, rv_decode_pkg::F7_MULDIV}: ctrl.alu_op = rv_decode_pkg::ALU_REMW;
                    default: bad = 1'b1;
                endcase
            end
            rv_decode_pkg::OPC_OP_IMM: begin
                ctrl.reg_wen = 1'b1;
                ctrl.rs1     = inst.i_fmt.rs1;
                ctrl.rd      = inst.i_fmt.rd;
                ctrl.alu_src = rv_decode_pkg::SRC_IMM;
                imm_sel      = rv_decode_pkg::IMM_I;
                case (funct3)
                    3'b000: ctrl.alu_op = rv_decode_pkg::ALU_ADD;
                    3'b011: ctrl.alu_op = rv_decode_pkg::ALU_SLTU;
                    3'b100: ctrl.alu_op = rv_decode_pkg::ALU_XOR;
                    3'b110: ctrl.alu_op = rv_decode_pkg::ALU_OR;
                    3'b111: ctrl.alu_op = rv_decode_pkg::ALU_AND;
                    3'b001: begin // slli, funct6 only
                        ctrl.alu_op = rv_decode_pkg::ALU_SLL;
                        imm_sel     = rv_decode_pkg::IMM_SHAMT;
                        bad         = (funct7[6:1] != rv_decode_pkg::F7_BASE[6:1]);
                    end
                    3'b101: begin // srai only
                        ctrl.alu_op = rv_decode_pkg::ALU_SRA;
                        imm_sel     = rv_decode_pkg::IMM_SHAMT;
                        bad         = (funct7[6:1] != rv_decode_pkg::F7_ALT[6:1]);
                    end
                    default: bad = 1'b1;
                endcase
            end
            rv_decode_pkg::OPC_OP_IMM_32: begin
                ctrl.reg_wen = 1'b1;
                ctrl.rs1     = inst.i_fmt.rs1;
                ctrl.rd      = inst.i_fmt.rd;
                ctrl.alu_src = rv_decode_pkg::SRC_IMM;
                ctrl.word_op = 1'b1;
                imm_sel      = rv_decode_pkg::IMM_SHAMT;
                case ({funct3, funct7})
                    {3'b001, rv_decode_pkg::F7_BASE}: ctrl.alu_op = rv_decode_pkg::ALU_SLL;
                    {3'b101, rv_decode_pkg::F7_BASE}: ctrl.alu_op = rv_decode_pkg::ALU_SRL;
                    {3'b101, rv_decode_pkg::F7_ALT}:  ctrl.alu_op = rv_decode_pkg::ALU_SRA;
                    default: begin
                        ctrl.alu_op = rv_decode_pkg::ALU_ADD;
                        imm_sel     = rv_decode_pkg::IMM_I; // addiw
                        bad         = (funct3 != 3'b000);
                    end
                endcase
            end
            rv_decode_pkg::OPC_LOAD: begin
                ctrl.reg_wen = 1'b1;
                ctrl.mem_re  = 1'b1;
                ctrl.rs1     = inst.i_fmt.rs1;
                ctrl.rd      = inst.i_fmt.rd;
                ctrl.alu_op  = rv_decode_pkg::ALU_ADD; // address = rs1 + imm
                ctrl.alu_src = rv_decode_pkg::SRC_IMM;
                imm_sel      = rv_decode_pkg::IMM_I;
                case (funct3)
                    3'b001: ctrl.mem_size = rv_decode_pkg::MEM_HALF; // lh
                    3'b010: ctrl.mem_size = rv_decode_pkg::MEM_WORD; // lw
                    3'b011: ctrl.mem_size = rv_decode_pkg::MEM_DOUBLE; // ld
                    3'b100: begin // lbu
                        ctrl.mem_size     = rv_decode_pkg::MEM_BYTE;
                        ctrl.mem_unsigned = 1'b1;
                    end
                    3'b101: begin // lhu
                        ctrl.mem_size     = rv_decode_pkg::MEM_HALF;
                        ctrl.mem_unsigned = 1'b1;
                    end
                    default: bad = 1'b1;
                endcase
            end
            rv_decode_pkg::OPC_STORE: begin
                ctrl.mem_we  = 1'b1;
                ctrl.rs1     = inst.s_fmt.rs1;
                ctrl.rs2     = inst.s_fmt.rs2;
                ctrl.alu_op  = rv_decode_pkg::ALU_ADD;
                ctrl.alu_src = rv_decode_pkg::SRC_IMM;
                imm_sel      = rv_decode_pkg::IMM_S;
                case (funct3)
                    3'b000: ctrl.mem_size = rv_decode_pkg::MEM_BYTE;
                    3'b001: ctrl.mem_size = rv_decode_pkg::MEM_HALF;
                    3'b010: ctrl.mem_size = rv_decode_pkg::MEM_WORD;
                    3'b011: ctrl.mem_size = rv_decode_pkg::MEM_DOUBLE;
                    default: bad = 1'b1;
                endcase
                // one mask bit per byte lane
                ctrl.wmask = 8'hff >> (8 - (1 << ctrl.mem_size));
            end
            rv_decode_pkg::OPC_BRANCH: begin
                ctrl.branch  = 1'b1;
                ctrl.rs1     = inst.b_fmt.rs1;
                ctrl.rs2     = inst.b_fmt.rs2;
                ctrl.alu_src = rv_decode_pkg::SRC_REG;
                imm_sel      = rv_decode_pkg::IMM_B;
                case (funct3)
                    3'b000: ctrl.alu_op = rv_decode_pkg::ALU_EQ;
                    3'b001: ctrl.alu_op = rv_decode_pkg::ALU_NE;
                    3'b100: ctrl.alu_op = rv_decode_pkg::ALU_LT;
                    3'b101: ctrl.alu_op = rv_decode_pkg::ALU_GE;
                    3'b110: ctrl.alu_op = rv_decode_pkg::ALU_LTU;
                    3'b111: ctrl.alu_op = rv_decode_pkg::ALU_GEU;
                    default: bad = 1'b1;
                endcase
            end
            rv_decode_pkg::OPC_JAL: begin
                ctrl.jump    = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.rd      = inst.j_fmt.rd;
                ctrl.alu_src = rv_decode_pkg::SRC_FOUR_PC; // link = pc + 4
                imm_sel      = rv_decode_pkg::IMM_J;
            end
            rv_decode_pkg::OPC_JALR: begin
                ctrl.jump    = 1'b1;
                ctrl.jalr    = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.rs1     = inst.i_fmt.rs1;
                ctrl.rd      = inst.i_fmt.rd;
                ctrl.alu_src = rv_decode_pkg::SRC_FOUR_PC;
                imm_sel      = rv_decode_pkg::IMM_I;
                bad          = (funct3 != 3'b000);
            end
            rv_decode_pkg::OPC_LUI, rv_decode_pkg::OPC_AUIPC: begin
                ctrl.reg_wen = 1'b1;
                ctrl.rd      = inst.u_fmt.rd;
                ctrl.alu_src = (opcode == rv_decode_pkg::OPC_LUI) ?
                               rv_decode_pkg::SRC_IMM : rv_decode_pkg::SRC_IMM_PC;
                imm_sel      = rv_decode_pkg::IMM_U;
            end
            rv_decode_pkg::OPC_SYSTEM: begin
                // only ebreak is recognised here
                ctrl.ebreak = (inst == rv_decode_pkg::EBREAK_WORD);
                bad         = !ctrl.ebreak;
            end
            default: bad = 1'b1;
        endcase

        if (bad) begin
            ctrl         = '0; // no side effects on a bad word
            ctrl.illegal = 1'b1;
            imm_sel      = rv_decode_pkg::IMM_NONE;
        end
    end

endmodule

// File: source/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
    input  rv_decode_pkg::inst_t             inst,
    input  rv_decode_pkg::imm_sel_e          imm_sel,
    output logic [rv_decode_pkg::XLEN-1:0]   imm
);

    rv_decode_pkg::i_fmt_t i_v;
    rv_decode_pkg::s_fmt_t s_v;
    rv_decode_pkg::b_fmt_t b_v;
    rv_decode_pkg::u_fmt_t u_v;
    rv_decode_pkg::j_fmt_t j_v;

    assign i_v = inst.i_fmt;
    assign s_v = inst.s_fmt;
    assign b_v = inst.b_fmt;
    assign u_v = inst.u_fmt;
    assign j_v = inst.j_fmt;

    // sign bit is inst[31] in every format
    always_comb begin
        case (imm_sel)
            rv_decode_pkg::IMM_I: begin
                imm = {{(rv_decode_pkg::XLEN-12){i_v.imm[11]}}, i_v.imm};
            end
            rv_decode_pkg::IMM_SHAMT: begin
                imm = {{(rv_decode_pkg::XLEN-6){1'b0}}, i_v.imm[5:0]}; // 6-bit shamt, zero filled
            end
            rv_decode_pkg::IMM_S: begin
                imm = {{(rv_decode_pkg::XLEN-12){s_v.imm_hi[6]}}, s_v.imm_hi, s_v.imm_lo};
            end
            rv_decode_pkg::IMM_B: begin
                imm = {{(rv_decode_pkg::XLEN-13){b_v.imm12}}, b_v.imm12, b_v.imm11,
                       b_v.imm10_5, b_v.imm4_1, 1'b0};
            end
            rv_decode_pkg::IMM_U: begin
                imm = {{(rv_decode_pkg::XLEN-32){u_v.imm[19]}}, u_v.imm, 12'b0};
            end
            rv_decode_pkg::IMM_J: begin
                imm = {{(rv_decode_pkg::XLEN-21){j_v.imm20}}, j_v.imm20, j_v.imm19_12,
                       j_v.imm11, j_v.imm10_1, 1'b0};
            end
            default: begin
                imm = '0; // none
            end
        endcase
    end

endmodule

// File: source/rv_decode_pkg.sv
package rv_decode_pkg;

    localparam int XLEN       = 64;
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000; // sub, sra
    localparam logic [6:0] F7_MULDIV = 7'b0000001; // M extension

    localparam logic [INST_W-1:0] EBREAK_WORD = 32'h0010_0073;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm12;
        logic [5:0]            imm10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm4_1;
        logic                  imm11;
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                  imm20;
        logic [9:0]            imm10_1;
        logic                  imm11;
        logic [7:0]            imm19_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_t;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_MUL, ALU_DIVU, ALU_REMU, ALU_DIVW,
        ALU_REMW, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_REG, SRC_IMM, SRC_IMM_PC, SRC_FOUR_PC
    } alu_src_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_SHAMT, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_sel_e;

    typedef enum logic [1:0] {
        MEM_BYTE, MEM_HALF, MEM_WORD, MEM_DOUBLE
    } mem_size_e;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_wen;
        logic                  branch;
        logic                  jump;
        logic                  jalr;
        alu_op_e               alu_op;
        alu_src_e              alu_src;
        logic                  mem_re;
        logic                  mem_we;
        mem_size_e             mem_size;
        logic                  mem_unsigned;
        logic [7:0]            wmask;
        logic                  word_op;
        logic                  illegal;
        logic                  ebreak;
    } ctrl_t;

    typedef struct packed {
        ctrl_t            ctrl;
        logic [XLEN-1:0]  imm;
    } decode_t;

endpackage
